//--- owt_frame_assembler.sv
/* frame state machine of the owt receiver
   counts the sync head, checks both tails, pairs symbols into Manchester
   bits and collects the command, data and crc fields */
`timescale 1ns/1ps
`include "owt_params.svh"

module owt_frame_assembler (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_rise,
    input  logic                        i_sym_vld,
    input  logic                        i_sym_level,
    output logic                        o_head_active,
    output logic                        o_bit_vld,
    output logic                        o_bit,
    output owt_pkg::owt_field_e         o_bit_field,
    output logic                        o_frame_end,
    output logic                        o_frame_abort,
    output logic                        o_tail_ok,
    output logic [`OWT_CMD_BIT_NUM-1:0] o_cmd,
    output owt_pkg::owt_data_u          o_data,
    output logic [`OWT_CRC_BIT_NUM-1:0] o_crc_rx
);
    import owt_pkg::*;

    localparam logic [2:0] ST_IDLE      = 3'd0;
    localparam logic [2:0] ST_HEAD      = 3'd1;
    localparam logic [2:0] ST_SYNC_TAIL = 3'd2;
    localparam logic [2:0] ST_CMD       = 3'd3;
    localparam logic [2:0] ST_ADC_DATA  = 3'd4;
    localparam logic [2:0] ST_NML_DATA  = 3'd5;
    localparam logic [2:0] ST_CRC       = 3'd6;
    localparam logic [2:0] ST_END_TAIL  = 3'd7;

    logic [2:0]                   state;
    logic [2:0]                   next_field;
    logic [3:0]                   cnt;
    logic [3:0]                   field_last;
    logic                         in_bits;
    logic                         pair_second;
    logic                         pair_first;
    logic                         bit_ok;
    logic                         bit_bad;
    logic [`OWT_TAIL_BIT_NUM-1:0] tail_sr;
    logic                         tail_match;
    logic                         cmd_start;
    logic [`OWT_CMD_BIT_NUM-1:0]  cmd_next;
    logic                         adc_sel;

    assign in_bits    = state inside {ST_CMD, ST_ADC_DATA, ST_NML_DATA, ST_CRC};
    // 1 is high then low, 0 is low then high
    assign bit_ok     = in_bits && i_sym_vld && pair_second && (pair_first != i_sym_level);
    assign bit_bad    = in_bits && i_sym_vld && pair_second && (pair_first == i_sym_level);
    assign tail_match = {tail_sr[`OWT_TAIL_BIT_NUM-2:0], i_sym_level} == `OWT_TAIL_PATTERN;
    assign cmd_start  = (state == ST_SYNC_TAIL) && i_sym_vld && (cnt == field_last) &&
                        tail_match;
    assign cmd_next   = {o_cmd[`OWT_CMD_BIT_NUM-2:0], pair_first};
    // read command with the adc address
    assign adc_sel    = !cmd_next[`OWT_CMD_BIT_NUM-1] &&
                        (cmd_next[`OWT_CMD_BIT_NUM-2:0] == `OWT_ADC_ADDR);

    assign o_head_active = (state == ST_HEAD);
    assign o_bit_vld     = bit_ok;
    assign o_bit         = pair_first;

    // field length, next field and bit tag per state
    always_comb begin
        field_last  = 4'(`OWT_CRC_BIT_NUM - 1);
        next_field  = ST_END_TAIL;
        o_bit_field = FIELD_CRC;
        case (state)
            ST_HEAD: begin
                field_last = 4'(`OWT_SYNC_BIT_NUM / 2 - 1);
            end
            ST_SYNC_TAIL, ST_END_TAIL: begin
                field_last = 4'(`OWT_TAIL_BIT_NUM - 1);
            end
            ST_CMD: begin
                field_last  = 4'(`OWT_CMD_BIT_NUM - 1);
                next_field  = adc_sel ? ST_ADC_DATA : ST_NML_DATA;
                o_bit_field = FIELD_CMD;
            end
            ST_ADC_DATA: begin
                field_last  = 4'(`OWT_ADCD_BIT_NUM - 1);
                next_field  = ST_CRC;
                o_bit_field = FIELD_DATA;
            end
            ST_NML_DATA: begin
                field_last  = 4'(`OWT_DATA_BIT_NUM - 1);
                next_field  = ST_CRC;
                o_bit_field = FIELD_DATA;
            end
            default: begin
                field_last = 4'(`OWT_CRC_BIT_NUM - 1);
            end
        endcase
    end

    // ==============================
    // frame state machine
    // ==============================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state         <= ST_IDLE;
            cnt           <= '0;
            pair_second   <= 1'b0;
            pair_first    <= 1'b0;
            tail_sr       <= '0;
            o_frame_end   <= 1'b0;
            o_frame_abort <= 1'b0;
            o_tail_ok     <= 1'b0;
        end else begin
            o_frame_end   <= 1'b0;
            o_frame_abort <= 1'b0;
            if (i_sym_vld) begin
                tail_sr <= {tail_sr[`OWT_TAIL_BIT_NUM-2:0], i_sym_level};
            end
            if (in_bits && i_sym_vld) begin
                pair_second <= ~pair_second;
                pair_first  <= i_sym_level;
            end
            case (state)
                ST_IDLE: begin
                    if (i_rise) begin
                        state <= ST_HEAD;
                        cnt   <= '0;
                    end
                end
                // first rise of the sync tail closes the head
                ST_HEAD: begin
                    if (i_rise && (cnt == field_last)) begin
                        state <= ST_SYNC_TAIL;
                        cnt   <= '0;
                    end else if (i_rise) begin
                        cnt <= cnt + 1'b1;
                    end
                end
                ST_SYNC_TAIL, ST_END_TAIL: begin
                    if (i_sym_vld && (cnt == field_last)) begin
                        cnt           <= '0;
                        state         <= cmd_start ? ST_CMD : ST_IDLE;
                        o_frame_abort <= (state == ST_SYNC_TAIL) && !tail_match;
                        o_frame_end   <= (state == ST_END_TAIL);
                        if (state == ST_END_TAIL) begin
                            o_tail_ok <= tail_match;
                        end
                    end else if (i_sym_vld) begin
                        cnt <= cnt + 1'b1;
                    end
                end
                ST_CMD, ST_ADC_DATA, ST_NML_DATA, ST_CRC: begin
                    if (bit_bad) begin
                        state         <= ST_IDLE;
                        cnt           <= '0;
                        pair_second   <= 1'b0;
                        o_frame_abort <= 1'b1;
                    end else if (bit_ok && (cnt == field_last)) begin
                        state <= next_field;
                        cnt   <= '0;
                    end else if (bit_ok) begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // ==============================
    // field registers
    // ==============================
    always_ff @(posedge i_clk) begin
        // short data lands in the low byte with zero pad
        if (cmd_start) begin
            o_data <= '0;
        end
        if (bit_ok && (state == ST_CMD)) begin
            o_cmd <= cmd_next;
        end
        if (bit_ok && ((state == ST_ADC_DATA) || (state == ST_NML_DATA))) begin
            o_data.adc <= {o_data.adc[`OWT_ADCD_BIT_NUM-2:0], pair_first};
        end
        if (bit_ok && (state == ST_CRC)) begin
            o_crc_rx <= {o_crc_rx[`OWT_CRC_BIT_NUM-2:0], pair_first};
        end
    end

endmodule

//--- owt_frame_checker.sv
/* frame checker of the owt receiver
   serial crc-8 over command and data bits, one acknowledge per frame */
`timescale 1ns/1ps
`include "owt_params.svh"

module owt_frame_checker (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_bit_vld,
    input  logic                        i_bit,
    input  owt_pkg::owt_field_e         i_bit_field,
    input  logic                        i_frame_end,
    input  logic                        i_frame_abort,
    input  logic                        i_tail_ok,
    input  logic [`OWT_CRC_BIT_NUM-1:0] i_crc_rx,
    output logic                        o_ack,
    output logic                        o_status
);
    import owt_pkg::*;

    logic [`OWT_CRC_BIT_NUM-1:0] crc;
    logic [`OWT_CRC_BIT_NUM-1:0] crc_base;
    logic [`OWT_CRC_BIT_NUM-1:0] crc_next;
    logic                        crc_fb;
    logic                        crc_en;
    logic                        cmd_seen;
    logic                        frame_done;

    assign crc_en     = i_bit_vld && (i_bit_field != FIELD_CRC);
    assign frame_done = i_frame_end || i_frame_abort;

    // restart on the first command bit
    assign crc_base = ((i_bit_field == FIELD_CMD) && !cmd_seen) ? '0 : crc;
    assign crc_fb   = crc_base[`OWT_CRC_BIT_NUM-1] ^ i_bit;
    assign crc_next = {crc_base[`OWT_CRC_BIT_NUM-2:0], 1'b0} ^
                      ({`OWT_CRC_BIT_NUM{crc_fb}} & `OWT_CRC_POLY);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            crc      <= '0;
            cmd_seen <= 1'b0;
        end else begin
            if (crc_en) begin
                crc <= crc_next;
            end
            if (frame_done) begin
                cmd_seen <= 1'b0;
            end else if (crc_en) begin
                cmd_seen <= 1'b1;
            end
        end
    end

    // ==============================
    // frame result
    // ==============================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_ack    <= 1'b0;
            o_status <= 1'b0;
        end else begin
            o_ack <= frame_done;
            // abort always fails
            if (frame_done) begin
                o_status <= i_frame_abort || !i_tail_ok || (crc != i_crc_rx);
            end
        end
    end

endmodule

//--- owt_line_sampler.sv
/* line front end of the owt receiver
   synchronizes the line, flags its edges, learns the symbol period from
   the sync head and samples one level per symbol for the frame assembler */
`timescale 1ns/1ps
`include "owt_params.svh"

module owt_line_sampler (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_owt_rx,
    input  logic i_head_active,
    output logic o_rise,
    output logic o_fall,
    output logic o_sym_vld,
    output logic o_sym_level
);

    logic                     rx_meta;
    logic                     rx_sync;
    logic                     rx_dly;
    logic                     head_q;
    logic                     edge_seen;
    logic                     sample_en;
    logic [`OWT_PERIOD_W-1:0] hi_cnt;
    logic [`OWT_PERIOD_W-1:0] period;
    logic [`OWT_PERIOD_W-1:0] phase;
    logic [`OWT_PERIOD_W-1:0] half_m1;

    // ==============================
    // synchronizer and edges
    // ==============================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rx_meta <= 1'b0;
            rx_sync <= 1'b0;
            rx_dly  <= 1'b0;
            o_rise  <= 1'b0;
            o_fall  <= 1'b0;
        end else begin
            rx_meta <= i_owt_rx;
            rx_sync <= rx_meta;
            rx_dly  <= rx_sync;
            o_rise  <= rx_sync & ~rx_dly;
            o_fall  <= ~rx_sync & rx_dly;
        end
    end

    assign edge_seen = o_rise | o_fall;

    // ==============================
    // period learning
    // ==============================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            hi_cnt <= '0;
            period <= '0;
            head_q <= 1'b0;
        end else begin
            head_q <= i_head_active;
            // saturating high pulse length
            if (o_rise) begin
                hi_cnt <= `OWT_PERIOD_W'(1);
            end else if (rx_dly && (hi_cnt != '1)) begin
                hi_cnt <= hi_cnt + 1'b1;
            end
            // relearn on a new head and keep the longest high pulse
            if (i_head_active && !head_q) begin
                period <= '0;
            end else if (i_head_active && o_fall && (hi_cnt > period)) begin
                period <= hi_cnt;
            end
        end
    end

    // ==============================
    // symbol sampling
    // ==============================
    assign half_m1   = (period >> 1) - 1'b1;
    assign sample_en = !i_head_active && (period >= `OWT_PERIOD_W'(2));

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            phase       <= '0;
            o_sym_vld   <= 1'b0;
            o_sym_level <= 1'b0;
        end else begin
            // edge cycle is phase 0
            if (edge_seen) begin
                phase <= `OWT_PERIOD_W'(1);
            end else if (phase >= period - 1'b1) begin
                phase <= '0;
            end else begin
                phase <= phase + 1'b1;
            end
            o_sym_vld   <= sample_en && !edge_seen && (phase == half_m1);
            o_sym_level <= rx_dly;
        end
    end

endmodule

//--- owt_link_monitor.sv
/* link monitor of the owt receiver
   saturating error score, raised on failed frames and lowered on good ones */
`timescale 1ns/1ps
`include "owt_params.svh"

module owt_link_monitor (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_ack,
    input  logic       i_status,
    input  logic       i_comerr_mode,
    input  logic [3:0] i_comerr_config,
    output logic       o_com_err
);

    localparam logic [15:0]                 ADD_TABLE = `OWT_ERR_ADD_TABLE;
    localparam logic [15:0]                 SUB_TABLE = `OWT_COR_SUB_TABLE;
    localparam logic [`OWT_ERR_CNT_W-1:0]   ERR_MAX   = `OWT_ERR_MAX;

    logic [`OWT_ERR_CNT_W-1:0] score;
    logic [`OWT_ERR_CNT_W-1:0] score_nxt;
    logic [`OWT_ERR_CNT_W:0]   sum;
    logic [3:0]                add_step;
    logic [3:0]                sub_step;

    assign add_step = ADD_TABLE[i_comerr_config[3:2]*4 +: 4];
    assign sub_step = SUB_TABLE[i_comerr_config[1:0]*4 +: 4];
    assign sum      = {1'b0, score} + {1'b0, add_step};

    always_comb begin
        score_nxt = score;
        if (i_ack && i_status) begin
            score_nxt = (sum >= {1'b0, ERR_MAX}) ? ERR_MAX : sum[`OWT_ERR_CNT_W-1:0];
        end else if (i_ack) begin
            score_nxt = (sub_step >= score) ? '0 : score - sub_step;
        end
    end

    // flag follows the new score in the same cycle it is stored
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            score     <= ERR_MAX;
            o_com_err <= 1'b1;
        end else begin
            score     <= score_nxt;
            o_com_err <= i_comerr_mode ? (score_nxt == '0) : (score_nxt >= add_step);
        end
    end

endmodule

//--- owt_params.svh
/* frame format, CRC and link error score constants of the owt receiver
   included by the package and by the RTL blocks that size their fields */
`ifndef OWT_PARAMS_SVH
`define OWT_PARAMS_SVH

// ==============================
// frame format
// ==============================
// sync head alternates high and low, starting high
`define OWT_SYNC_BIT_NUM    12
`define OWT_TAIL_BIT_NUM    4
`define OWT_TAIL_PATTERN    4'b1100
`define OWT_CMD_BIT_NUM     8
`define OWT_DATA_BIT_NUM    8
`define OWT_ADCD_BIT_NUM    10
`define OWT_CRC_BIT_NUM     8

// read of this address carries the long data field
`define OWT_ADC_ADDR        7'h1f

// crc-8, zero start, msb first
`define OWT_CRC_POLY        8'h07

// symbol period counter
`define OWT_PERIOD_W        8

// ==============================
// link error score
// ==============================
`define OWT_ERR_CNT_W       4
`define OWT_ERR_MAX         15

// four steps each, entry 0 in the low nibble
`define OWT_ERR_ADD_TABLE   {4'd8, 4'd4, 4'd2, 4'd1}
`define OWT_COR_SUB_TABLE   {4'd4, 4'd3, 4'd2, 4'd1}

`endif

//--- owt_pkg.sv
/* shared types of the owt receiver
   field tag of a decoded bit and the two views of the received data word */
`include "owt_params.svh"

package owt_pkg;

    typedef enum logic [1:0] {
        FIELD_CMD  = 2'd0,
        FIELD_DATA = 2'd1,
        FIELD_CRC  = 2'd2
    } owt_field_e;

    // adc frames fill all ten bits, register frames only the low byte
    typedef union packed {
        logic [`OWT_ADCD_BIT_NUM-1:0] adc;
        struct packed {
            logic [`OWT_ADCD_BIT_NUM-`OWT_DATA_BIT_NUM-1:0] pad;
            logic [`OWT_DATA_BIT_NUM-1:0]                   value;
        } regv;
    } owt_data_u;

endpackage

//--- owt_rx.sv
/* top level of the owt Manchester receiver
   sampler feeds the frame assembler, the checker reports each frame and
   the link monitor scores the results */
`timescale 1ns/1ps
`include "owt_params.svh"

module owt_rx (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_owt_rx,
    input  logic                        i_comerr_mode,
    input  logic [3:0]                  i_comerr_config,
    output logic                        o_rx_ack,
    output logic                        o_rx_status,
    output logic [`OWT_CMD_BIT_NUM-1:0] o_rx_cmd,
    output owt_pkg::owt_data_u          o_rx_data,
    output logic                        o_com_err
);
    import owt_pkg::*;

    logic                        rise;
    logic                        sym_vld;
    logic                        sym_level;
    logic                        head_active;
    logic                        bit_vld;
    logic                        bit_val;
    owt_field_e                  bit_field;
    logic                        frame_end;
    logic                        frame_abort;
    logic                        tail_ok;
    logic [`OWT_CRC_BIT_NUM-1:0] crc_rx;

    owt_line_sampler u_line_sampler (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_owt_rx      (i_owt_rx),
        .i_head_active (head_active),
        .o_rise        (rise),
        .o_fall        (),
        .o_sym_vld     (sym_vld),
        .o_sym_level   (sym_level)
    );

    owt_frame_assembler u_frame_assembler (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_rise        (rise),
        .i_sym_vld     (sym_vld),
        .i_sym_level   (sym_level),
        .o_head_active (head_active),
        .o_bit_vld     (bit_vld),
        .o_bit         (bit_val),
        .o_bit_field   (bit_field),
        .o_frame_end   (frame_end),
        .o_frame_abort (frame_abort),
        .o_tail_ok     (tail_ok),
        .o_cmd         (o_rx_cmd),
        .o_data        (o_rx_data),
        .o_crc_rx      (crc_rx)
    );

    owt_frame_checker u_frame_checker (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_bit_vld     (bit_vld),
        .i_bit         (bit_val),
        .i_bit_field   (bit_field),
        .i_frame_end   (frame_end),
        .i_frame_abort (frame_abort),
        .i_tail_ok     (tail_ok),
        .i_crc_rx      (crc_rx),
        .o_ack         (o_rx_ack),
        .o_status      (o_rx_status)
    );

    owt_link_monitor u_link_monitor (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_ack           (o_rx_ack),
        .i_status        (o_rx_status),
        .i_comerr_mode   (i_comerr_mode),
        .i_comerr_config (i_comerr_config),
        .o_com_err       (o_com_err)
    );

endmodule

//--- owt_rx_asserts.sv
/* concurrent checks on the owt receiver pulses
   bound into every owt_rx instance by the bind statement at the end */
`timescale 1ns/1ps

module owt_rx_asserts (
    input logic i_clk,
    input logic i_rst_n,
    input logic i_rx_ack,
    input logic i_frame_end,
    input logic i_frame_abort,
    input logic i_sym_vld
);

    int assert_fail_cnt;

    initial assert_fail_cnt = 0;

    // acknowledge is a single-cycle pulse
    ack_one_cycle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_rx_ack |=> !i_rx_ack)
    else begin
        $error("o_rx_ack stayed high for more than one cycle");
        assert_fail_cnt++;
    end

    end_abort_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_frame_end && i_frame_abort))
    else begin
        $error("frame end and frame abort high in the same cycle");
        assert_fail_cnt++;
    end

    // symbols at least two cycles apart
    sym_spacing: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_sym_vld |=> !i_sym_vld)
    else begin
        $error("symbol pulses closer than two cycles");
        assert_fail_cnt++;
    end

endmodule

bind owt_rx owt_rx_asserts u_owt_rx_asserts (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_rx_ack      (o_rx_ack),
    .i_frame_end   (frame_end),
    .i_frame_abort (frame_abort),
    .i_sym_vld     (sym_vld)
);

//--- owt_rx_tb.sv
/* directed testbench of the owt Manchester receiver
   encodes frames onto the line at 8 clocks per symbol and checks each
   acknowledge, the decoded fields and the link error flag */
`timescale 1ns/1ps
`include "owt_params.svh"

module owt_rx_tb;
    import owt_pkg::*;

    localparam int SYM_CLKS       = 8;
    localparam int GAP_SYMBOLS    = 6;
    localparam int ACK_WAIT       = 4 * SYM_CLKS;
    // room for 20 frames of 120 symbols
    localparam int TIMEOUT_CYCLES = 20 * 120 * SYM_CLKS;

    logic       i_clk;
    logic       i_rst_n;
    logic       i_owt_rx;
    logic       i_comerr_mode;
    logic [3:0] i_comerr_config;
    logic       o_rx_ack;
    logic       o_rx_status;
    logic [7:0] o_rx_cmd;
    owt_data_u  o_rx_data;
    logic       o_com_err;

    integer     seed;
    int         mismatch_count;
    int         fail_count;
    int         ack_count;
    int         acks_expected;
    int         cycle_cnt;
    logic       ack_status;
    logic [7:0] ack_cmd;
    owt_data_u  ack_data;

    owt_rx owt_rx_i (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_owt_rx        (i_owt_rx),
        .i_comerr_mode   (i_comerr_mode),
        .i_comerr_config (i_comerr_config),
        .o_rx_ack        (o_rx_ack),
        .o_rx_status     (o_rx_status),
        .o_rx_cmd        (o_rx_cmd),
        .o_rx_data       (o_rx_data),
        .o_com_err       (o_com_err)
    );

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    // result capture at each acknowledge
    always @(posedge i_clk) begin
        if (o_rx_ack) begin
            ack_count  <= ack_count + 1;
            ack_status <= o_rx_status;
            ack_cmd    <= o_rx_cmd;
            ack_data   <= o_rx_data;
        end
    end

    // ==============================
    // helpers
    // ==============================
    function automatic logic [7:0] ref_crc8(input logic [17:0] bits, input int nbits);
        logic [7:0] crc;
        logic       fb;
        int         i;
        crc = 8'h00;
        for (i = nbits - 1; i >= 0; i--) begin
            fb  = crc[7] ^ bits[i];
            crc = {crc[6:0], 1'b0};
            if (fb) begin
                crc = crc ^ `OWT_CRC_POLY;
            end
        end
        return crc;
    endfunction

    task automatic check_value(input string test, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            mismatch_count++;
            $display("mismatch %s %s: expected %0h, actual %0h", test, what, exp, act);
        end
    endtask

    task automatic reset_dut;
        i_rst_n <= 1'b0;
        repeat (3) @(posedge i_clk);
        i_rst_n <= 1'b1;
        @(posedge i_clk);
    endtask

    task automatic drive_symbol(input logic level);
        i_owt_rx <= level;
        repeat (SYM_CLKS) @(posedge i_clk);
    endtask

    // 1 is high then low
    task automatic manchester_bit(input logic b);
        drive_symbol(b);
        drive_symbol(~b);
    endtask

    task automatic hold_idle(input int symbols);
        repeat (symbols) drive_symbol(1'b0);
    endtask

    // viol_bit >= 0 replaces that data bit with a low-low pair and stops
    task automatic transmit_frame(input logic [7:0] cmd, input logic [9:0] data,
                                  input int data_bits, input logic [7:0] crc_mask,
                                  input int viol_bit, input logic [3:0] end_tail);
        logic [17:0] payload;
        logic [7:0]  crc;
        logic [3:0]  sync_tail;
        int          i;
        payload   = (data_bits == 10) ? {cmd, data} : {2'b00, cmd, data[7:0]};
        crc       = ref_crc8(payload, 8 + data_bits) ^ crc_mask;
        sync_tail = `OWT_TAIL_PATTERN;
        for (i = 0; i < `OWT_SYNC_BIT_NUM; i++) begin
            drive_symbol(i % 2 == 0);
        end
        for (i = 3; i >= 0; i--) begin
            drive_symbol(sync_tail[i]);
        end
        for (i = 7; i >= 0; i--) begin
            manchester_bit(cmd[i]);
        end
        for (i = data_bits - 1; i >= 0; i--) begin
            if (i == viol_bit) begin
                drive_symbol(1'b0);
                drive_symbol(1'b0);
                hold_idle(GAP_SYMBOLS);
                return;
            end
            manchester_bit(data[i]);
        end
        for (i = 7; i >= 0; i--) begin
            manchester_bit(crc[i]);
        end
        for (i = 3; i >= 0; i--) begin
            drive_symbol(end_tail[i]);
        end
        hold_idle(GAP_SYMBOLS);
    endtask

    task automatic wait_ack(input string test);
        int n;
        n = 0;
        acks_expected++;
        while ((ack_count < acks_expected) && (n < ACK_WAIT)) begin
            @(posedge i_clk);
            n++;
        end
        assert (ack_count >= acks_expected) else begin
            fail_count++;
            $display("%s: the DUT gave no acknowledge for the frame", test);
        end
        check_value(test, "ack count", acks_expected, ack_count);
    endtask

    // ==============================
    // directed tests
    // ==============================
    task automatic idle_after_reset;
        check_value("idle_after_reset", "com_err", 1, o_com_err);
        hold_idle(12);
        check_value("idle_after_reset", "ack count", 0, ack_count);
    endtask

    task automatic write_frame_ok;
        logic [31:0] rnd;
        logic [7:0]  cmd;
        logic [7:0]  dat;
        rnd = $random(seed);
        cmd = {1'b1, rnd[6:0]};
        dat = rnd[15:8];
        transmit_frame(cmd, {2'b00, dat}, 8, 8'h00, -1, `OWT_TAIL_PATTERN);
        wait_ack("write_frame_ok");
        check_value("write_frame_ok", "status", 0, ack_status);
        check_value("write_frame_ok", "cmd", cmd, ack_cmd);
        check_value("write_frame_ok", "reg value", dat, ack_data.regv.value);
        check_value("write_frame_ok", "reg pad", 0, ack_data.regv.pad);
    endtask

    task automatic adc_read_ok;
        logic [31:0] rnd;
        logic [9:0]  sample;
        rnd    = $random(seed);
        sample = rnd[9:0];
        transmit_frame({1'b0, `OWT_ADC_ADDR}, sample, 10, 8'h00, -1, `OWT_TAIL_PATTERN);
        wait_ack("adc_read_ok");
        check_value("adc_read_ok", "status", 0, ack_status);
        check_value("adc_read_ok", "cmd", {1'b0, `OWT_ADC_ADDR}, ack_cmd);
        check_value("adc_read_ok", "adc sample", sample, ack_data.adc);
    endtask

    task automatic bad_frames_fail;
        logic [31:0] rnd;
        rnd = $random(seed);
        transmit_frame({1'b1, rnd[6:0]}, {2'b00, rnd[15:8]}, 8, 8'h10, -1, `OWT_TAIL_PATTERN);
        wait_ack("bad_crc");
        check_value("bad_crc", "status", 1, ack_status);
        transmit_frame({1'b1, rnd[22:16]}, {2'b00, rnd[31:24]}, 8, 8'h00, 3, `OWT_TAIL_PATTERN);
        wait_ack("data_violation");
        check_value("data_violation", "status", 1, ack_status);
        transmit_frame({1'b1, rnd[14:8]}, {2'b00, rnd[7:0]}, 8, 8'h00, -1, 4'b1010);
        wait_ack("bad_end_tail");
        check_value("bad_end_tail", "status", 1, ack_status);
    endtask

    // add and subtract steps are both 1 with config 0
    task automatic error_score_tracks;
        logic [31:0] rnd;
        int          score;
        int          i;
        i_comerr_mode   <= 1'b0;
        i_comerr_config <= 4'b0000;
        reset_dut;
        score = `OWT_ERR_MAX;
        check_value("error_score", "com_err after reset", 1, o_com_err);
        for (i = 0; i < 16; i++) begin
            rnd = $random(seed);
            transmit_frame({1'b1, rnd[6:0]}, {2'b00, rnd[15:8]}, 8, 8'h00, -1,
                           `OWT_TAIL_PATTERN);
            score = (score > 0) ? score - 1 : 0;
            wait_ack("error_score");
            check_value("error_score", "good status", 0, ack_status);
            check_value("error_score", "mode 0 com_err", score >= 1, o_com_err);
        end
        rnd = $random(seed);
        transmit_frame({1'b1, rnd[6:0]}, {2'b00, rnd[15:8]}, 8, 8'h01, -1, `OWT_TAIL_PATTERN);
        score = (score + 1 > `OWT_ERR_MAX) ? `OWT_ERR_MAX : score + 1;
        wait_ack("error_score");
        check_value("error_score", "bad status", 1, ack_status);
        check_value("error_score", "com_err after bad", score >= 1, o_com_err);
        i_comerr_mode <= 1'b1;
        repeat (2) @(posedge i_clk);
        check_value("error_score", "mode 1 com_err", score == 0, o_com_err);
        transmit_frame({1'b1, rnd[22:16]}, {2'b00, rnd[31:24]}, 8, 8'h00, -1,
                       `OWT_TAIL_PATTERN);
        score = (score > 0) ? score - 1 : 0;
        wait_ack("error_score");
        check_value("error_score", "mode 1 com_err at 0", score == 0, o_com_err);
    endtask

    // ==============================
    // run control
    // ==============================
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge i_clk);
            cycle_cnt++;
        end
        $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        i_rst_n         = 1'b0;
        i_owt_rx        = 1'b0;
        i_comerr_mode   = 1'b0;
        i_comerr_config = 4'b0000;
        seed            = 32'h3156_410f;
        mismatch_count  = 0;
        fail_count      = 0;
        ack_count       = 0;
        acks_expected   = 0;
        reset_dut;
        idle_after_reset;
        write_frame_ok;
        adc_read_ok;
        bad_frames_fail;
        error_score_tracks;
        $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatch_count, fail_count, owt_rx_i.u_owt_rx_asserts.assert_fail_cnt);
        if ((mismatch_count + fail_count + owt_rx_i.u_owt_rx_asserts.assert_fail_cnt) == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+.
owt_pkg.sv
owt_line_sampler.sv
owt_frame_assembler.sv
owt_frame_checker.sv
owt_link_monitor.sv
owt_rx.sv
owt_rx_asserts.sv
owt_rx_tb.sv
